// File: vid_timing.f
logic/vid_pkg.sv
logic/vid_regs.sv
logic/vid_counter.sv
logic/vid_flags.sv
logic/vid_timing.sv
tb/tb_clock.sv
tb/tb_vid_timing.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the video timing testbench with Verilator, runs it and judges the log
set -e
set -o pipefail
cd "$(dirname "$0")"

log=sim.log
rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
	--top-module tb_vid_timing -f vid_timing.f
./obj_dir/Vtb_vid_timing | tee "$log"

if grep -q "^Test passed$" "$log"; then
	exit 0
fi
echo "Simulation did not report success, see $log"
exit 1

// File: tb/tb_vid_timing.sv
/* Checks vid_timing against a reference position and flag model on short periods
   pix_en gaps are capped at max_gap cycles, which bounds every wait and the watchdog */
`timescale 1ns/1ps

module tb_vid_timing;

	localparam int hpos_w = vid_pkg::HPOS_W;
	localparam int vpos_w = vid_pkg::VPOS_W;
	localparam int max_gap = 4;
	// Timing programme, half and field bits sit just above the count
	localparam int hp_i = 9;
	localparam int hbb_i = 7;
	localparam int hbe_i = (1 << hpos_w) + 1;
	localparam int hdb_i = (1 << hpos_w) + 3;
	localparam int hde_i = (1 << hpos_w) + 8;
	localparam int hs_i = 6;
	localparam int vp_i = 7;
	localparam int vbb_i = 6;
	localparam int vbe_i = (1 << vpos_w) + 1;
	localparam int vdb_i = 2;
	localparam int vde_i = 5;
	localparam int vs_i = 6;
	localparam int vi_i = 3;
	// Two fields of (vp+1) half-lines, each half-line hp+1 pixels
	localparam int frame_cyc = 2 * (vp_i + 1) * (hp_i + 1) * max_gap;
	localparam int watchdog_cyc = 20 * frame_cyc;

	logic sys_clk;
	logic resetl;
	logic pix_en = 1'b0;
	logic wr;
	logic [vid_pkg::ADDR_W-1:0] addr;
	logic [vid_pkg::DATA_W-1:0] data;
	logic [hpos_w-1:0] hpos;
	logic half;
	logic [vpos_w-1:0] vpos;
	logic field;
	logic hblank, vblank, blank, hsync, vsync, vactive, vint;

	// Reference model state
	logic m_viden;
	logic [hpos_w-1:0] m_hpos;
	logic m_half;
	logic [vpos_w-1:0] m_vpos;
	logic m_field;
	logic m_hblank, m_vblank, m_blank, m_hsync, m_vsync, m_v_win, m_vactive, m_vint;

	integer seed = 32'h9ea49980;
	int gap = 0;
	int errors = 0;
	int passed = 0;
	int failed = 0;

	tb_clock #(.reset_cycles(8)) clk_i (.sys_clk(sys_clk), .resetl(resetl));

	vid_timing #(.hpos_w(hpos_w), .vpos_w(vpos_w)) dut_i (
		.sys_clk(sys_clk), .resetl(resetl), .pix_en(pix_en),
		.wr(wr), .addr(addr), .data(data),
		.hpos(hpos), .half(half), .vpos(vpos), .field(field),
		.hblank(hblank), .vblank(vblank), .blank(blank),
		.hsync(hsync), .vsync(vsync), .vactive(vactive), .vint(vint)
	);

	// Random strobe about every other cycle, forced once the gap reaches max_gap
	always @(posedge sys_clk) begin : strobe_gen
		logic nxt;
		nxt = (($random(seed) & 32'd1) != 0) || (gap == max_gap - 1);
		pix_en <= resetl && nxt;
		gap <= nxt ? 0 : gap + 1;
	end

	// Positions and flags as the timing rules predict them, one cycle after the strobe
	always @(posedge sys_clk) begin : ref_model
		int hcur;
		int vcur;
		logic h_end;
		logic v_end;
		logic hb;
		logic vb;
		hcur = int'({m_half, m_hpos});
		vcur = int'({m_field, m_vpos});
		h_end = (int'(m_hpos) == hp_i);
		v_end = h_end && (int'(m_vpos) == vp_i);
		hb = m_hblank;
		vb = m_vblank;
		// A flag moves only when exactly one of its compares hits
		if ((hcur == hbb_i) != (hcur == hbe_i))
			hb = (hcur == hbb_i);
		if ((vcur == vbb_i) != (vcur == vbe_i))
			vb = (vcur == vbb_i);
		if (!resetl)
			m_viden <= 1'b0;
		else if (wr && addr == vid_pkg::REG_MODE)
			m_viden <= data[vid_pkg::MODE_VIDEN];
		if (!resetl || !m_viden) begin
			m_hpos <= '0;
			m_half <= 1'b0;
			m_vpos <= '0;
			m_field <= 1'b0;
			m_hblank <= 1'b0;
			m_vblank <= 1'b0;
			m_blank <= 1'b0;
			m_hsync <= 1'b0;
			m_vsync <= 1'b0;
			m_v_win <= 1'b0;
			m_vactive <= 1'b0;
			m_vint <= 1'b0;
		end else begin
			m_vint <= pix_en && (vcur == vi_i) && (hcur == hde_i);
			if (pix_en) begin
				m_hpos <= h_end ? '0 : m_hpos + 1'b1;
				m_half <= m_half ^ h_end;
				// Vertical steps once per half-line
				if (h_end) begin
					m_vpos <= v_end ? '0 : m_vpos + 1'b1;
					m_field <= m_field ^ v_end;
				end
				m_hblank <= hb;
				m_vblank <= vb;
				m_blank <= hb | vb;
				if ((hcur == hs_i) != h_end)
					m_hsync <= h_end ? 1'b0 : 1'b1;
				if ((vcur == vs_i) != v_end)
					m_vsync <= v_end ? 1'b0 : 1'b1;
				if ((vcur == vdb_i) != (vcur == vde_i))
					m_v_win <= (vcur == vdb_i);
				if (((hcur == hdb_i) && m_v_win) != (hcur == hde_i))
					m_vactive <= (hcur == hde_i) ? 1'b0 : 1'b1;
			end
		end
	end

	task automatic report_mismatch(input string name, input int expv, input int actv);
		errors++;
		$display("[ERROR] t=%0t %s expected %0d got %0d", $time, name, expv, actv);
	endtask

	a_hpos: assert property (@(posedge sys_clk) disable iff (!resetl) hpos === m_hpos)
		else report_mismatch("hpos", int'($sampled(m_hpos)), int'($sampled(hpos)));
	a_half: assert property (@(posedge sys_clk) disable iff (!resetl) half === m_half)
		else report_mismatch("half", int'($sampled(m_half)), int'($sampled(half)));
	a_vpos: assert property (@(posedge sys_clk) disable iff (!resetl) vpos === m_vpos)
		else report_mismatch("vpos", int'($sampled(m_vpos)), int'($sampled(vpos)));
	a_field: assert property (@(posedge sys_clk) disable iff (!resetl) field === m_field)
		else report_mismatch("field", int'($sampled(m_field)), int'($sampled(field)));
	a_hblank: assert property (@(posedge sys_clk) disable iff (!resetl) hblank === m_hblank)
		else report_mismatch("hblank", int'($sampled(m_hblank)), int'($sampled(hblank)));
	a_vblank: assert property (@(posedge sys_clk) disable iff (!resetl) vblank === m_vblank)
		else report_mismatch("vblank", int'($sampled(m_vblank)), int'($sampled(vblank)));
	a_blank: assert property (@(posedge sys_clk) disable iff (!resetl) blank === m_blank)
		else report_mismatch("blank", int'($sampled(m_blank)), int'($sampled(blank)));
	a_hsync: assert property (@(posedge sys_clk) disable iff (!resetl) hsync === m_hsync)
		else report_mismatch("hsync", int'($sampled(m_hsync)), int'($sampled(hsync)));
	a_vsync: assert property (@(posedge sys_clk) disable iff (!resetl) vsync === m_vsync)
		else report_mismatch("vsync", int'($sampled(m_vsync)), int'($sampled(vsync)));
	a_vactive: assert property (@(posedge sys_clk) disable iff (!resetl) vactive === m_vactive)
		else report_mismatch("vactive", int'($sampled(m_vactive)), int'($sampled(vactive)));
	a_vint: assert property (@(posedge sys_clk) disable iff (!resetl) vint === m_vint)
		else report_mismatch("vint", int'($sampled(m_vint)), int'($sampled(vint)));

	// Events the tests wait on, 0 half, 1 field, 2 vint, 3 vpos at 3, 4 counters cleared
	function automatic logic watched(input int sel);
		case (sel)
			0: return half;
			1: return field;
			2: return vint;
			3: return int'(vpos) == 3;
			default: return hpos == '0 && vpos == '0 && !half && !field;
		endcase
	endfunction

	// Counts rising edges of a watched event, sampled at the falling edge
	task automatic wait_rises(input int sel, input int n, input int limit, output bit ok);
		int seen;
		int cyc;
		logic prev;
		seen = 0;
		cyc = 0;
		prev = watched(sel);
		while (seen < n && cyc < limit) begin
			@(negedge sys_clk);
			cyc++;
			if (watched(sel) && !prev)
				seen++;
			prev = watched(sel);
		end
		ok = (seen >= n);
	endtask

	task automatic wait_strobes(input int n);
		int seen;
		seen = 0;
		while (seen < n) begin
			@(negedge sys_clk);
			if (pix_en)
				seen++;
		end
	endtask

	task automatic write_reg(input logic [vid_pkg::ADDR_W-1:0] a, input int value);
		@(posedge sys_clk);
		wr <= 1'b1;
		addr <= a;
		data <= vid_pkg::DATA_W'(value);
		@(posedge sys_clk);
		wr <= 1'b0;
	endtask

	task automatic close_test(input string name, input bit ok, input int mark);
		if (ok && errors == mark) begin
			passed++;
			$display("PASS  %s", name);
		end else begin
			failed++;
			if (!ok)
				$display("%s: awaited event did not occur within its limit", name);
			$display("FAIL  %s", name);
		end
	endtask

	initial begin : main
		int mark;
		bit ok;
		wr <= 1'b0;
		addr <= '0;
		data <= '0;
		@(posedge resetl);

		// Disabled generator must stay idle while strobes arrive
		mark = errors;
		wait_strobes(30);
		close_test("idle after reset", 1'b1, mark);

		// Timing first, enable last
		mark = errors;
		write_reg(vid_pkg::REG_HP, hp_i);
		write_reg(vid_pkg::REG_HBB, hbb_i);
		write_reg(vid_pkg::REG_HBE, hbe_i);
		write_reg(vid_pkg::REG_HDB, hdb_i);
		write_reg(vid_pkg::REG_HDE, hde_i);
		write_reg(vid_pkg::REG_HS, hs_i);
		write_reg(vid_pkg::REG_VP, vp_i);
		write_reg(vid_pkg::REG_VBB, vbb_i);
		write_reg(vid_pkg::REG_VBE, vbe_i);
		write_reg(vid_pkg::REG_VDB, vdb_i);
		write_reg(vid_pkg::REG_VDE, vde_i);
		write_reg(vid_pkg::REG_VS, vs_i);
		write_reg(vid_pkg::REG_VI, vi_i);
		write_reg(vid_pkg::REG_MODE, 1);
		wait_rises(0, 3, frame_cyc, ok);
		close_test("horizontal count and half", ok, mark);

		mark = errors;
		wait_rises(1, 2, 3 * frame_cyc, ok);
		close_test("vertical count and field", ok, mark);

		mark = errors;
		wait_rises(1, 1, 2 * frame_cyc, ok);
		close_test("blanking and sync windows", ok, mark);

		mark = errors;
		wait_rises(2, 2, 3 * frame_cyc, ok);
		close_test("display window and interrupt", ok, mark);

		// Disable in mid-frame, counters are back at 0 two cycles after the write
		mark = errors;
		wait_rises(3, 1, 2 * frame_cyc, ok);
		if (ok) begin
			write_reg(vid_pkg::REG_MODE, 0);
			wait_rises(4, 1, 4, ok);
			wait_strobes(20);
		end
		close_test("disable in mid-frame", ok, mark);

		$display("Tests: %0d passed, %0d failed, %0d value errors", passed, failed, errors);
		if (failed == 0 && errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	// Twenty frames at the widest strobe spacing
	initial begin : watchdog
		repeat (watchdog_cyc) @(posedge sys_clk);
		$display("Watchdog expired after %0d cycles, run stopped", watchdog_cyc);
		$display("Test failed");
		$finish;
	end

endmodule

// File: tb/tb_clock.sv
/* 10 ns clock from time 0, resetl low for reset_cycles rising edges
   Reset is released on a rising edge, for a synchronous reset */
`timescale 1ns/1ps

module tb_clock #(
	parameter int reset_cycles = 8
) (
	output logic sys_clk,
	output logic resetl
);

	// Free-running clock, 5 ns per phase
	initial begin
		sys_clk = 1'b0;
		forever #5 sys_clk = ~sys_clk;
	end

	initial begin
		resetl = 1'b0;
		repeat (reset_cycles) @(posedge sys_clk);
		resetl <= 1'b1;
	end

endmodule

// File: logic/vid_timing.sv
/* Video timing generator, all state advances on the pix_en strobe in the sys_clk domain
   Outputs are registered and lag the causing pix_en by one cycle */
`timescale 1ns/1ps

module vid_timing #(
	parameter int hpos_w = vid_pkg::HPOS_W,
	parameter int vpos_w = vid_pkg::VPOS_W
) (
	input  logic                       sys_clk,
	input  logic                       resetl,
	input  logic                       pix_en,
	input  logic                       wr,
	input  logic [vid_pkg::ADDR_W-1:0] addr,
	input  logic [vid_pkg::DATA_W-1:0] data,
	output logic [hpos_w-1:0]          hpos,
	output logic                       half,
	output logic [vpos_w-1:0]          vpos,
	output logic                       field,
	output logic                       hblank,
	output logic                       vblank,
	output logic                       blank,
	output logic                       hsync,
	output logic                       vsync,
	output logic                       vactive,
	output logic                       vint
);

	logic              viden;
	logic [hpos_w-1:0] h_period;
	logic [hpos_w:0]   hbb, hbe, hdb, hde, hs;
	logic [vpos_w-1:0] v_period;
	logic [vpos_w:0]   vbb, vbe, vdb, vde, vs, vi;
	logic              h_wrap;
	logic              v_wrap;

	vid_regs #(.hpos_w(hpos_w), .vpos_w(vpos_w)) regs_i (
		.sys_clk(sys_clk), .resetl(resetl), .wr(wr), .addr(addr), .data(data),
		.viden(viden), .h_period(h_period),
		.hbb(hbb), .hbe(hbe), .hdb(hdb), .hde(hde), .hs(hs),
		.v_period(v_period),
		.vbb(vbb), .vbe(vbe), .vdb(vdb), .vde(vde), .vs(vs), .vi(vi)
	);

	// Pixels within a half-line
	vid_counter #(.cnt_w(hpos_w)) h_cnt_i (
		.sys_clk(sys_clk), .resetl(resetl), .clear(~viden), .en(pix_en),
		.period(h_period), .count(hpos), .toggle(half), .wrap(h_wrap)
	);

	// Half-lines within a field, stepped by the horizontal wrap
	vid_counter #(.cnt_w(vpos_w)) v_cnt_i (
		.sys_clk(sys_clk), .resetl(resetl), .clear(~viden), .en(h_wrap),
		.period(v_period), .count(vpos), .toggle(field), .wrap(v_wrap)
	);

	vid_flags #(.hpos_w(hpos_w), .vpos_w(vpos_w)) flags_i (
		.sys_clk(sys_clk), .resetl(resetl), .viden(viden), .pix_en(pix_en),
		.h_wrap(h_wrap), .v_wrap(v_wrap),
		// Compares see the toggle bit as the top bit of the position
		.h_pos({half, hpos}), .v_pos({field, vpos}),
		.hbb(hbb), .hbe(hbe), .hdb(hdb), .hde(hde), .hs(hs),
		.vbb(vbb), .vbe(vbe), .vdb(vdb), .vde(vde), .vs(vs), .vi(vi),
		.hblank(hblank), .vblank(vblank), .blank(blank),
		.hsync(hsync), .vsync(vsync), .vactive(vactive), .vint(vint)
	);

endmodule

// File: logic/vid_flags.sv
/* Timing flags set and cleared by position compares, sampled on pix_en
   All flags read 0 while video is disabled, vint is a single-cycle pulse */
`timescale 1ns/1ps

module vid_flags #(
	parameter int hpos_w = vid_pkg::HPOS_W,
	parameter int vpos_w = vid_pkg::VPOS_W
) (
	input  logic            sys_clk,
	input  logic            resetl,
	input  logic            viden,
	input  logic            pix_en,
	input  logic            h_wrap,
	input  logic            v_wrap,
	input  logic [hpos_w:0] h_pos,
	input  logic [vpos_w:0] v_pos,
	input  logic [hpos_w:0] hbb,
	input  logic [hpos_w:0] hbe,
	input  logic [hpos_w:0] hdb,
	input  logic [hpos_w:0] hde,
	input  logic [hpos_w:0] hs,
	input  logic [vpos_w:0] vbb,
	input  logic [vpos_w:0] vbe,
	input  logic [vpos_w:0] vdb,
	input  logic [vpos_w:0] vde,
	input  logic [vpos_w:0] vs,
	input  logic [vpos_w:0] vi,
	output logic            hblank,
	output logic            vblank,
	output logic            blank,
	output logic            hsync,
	output logic            vsync,
	output logic            vactive,
	output logic            vint
);

	logic v_win;
	logic hblank_nxt;
	logic vblank_nxt;

	// Set wins alone, clear wins alone, both together hold
	function automatic logic sr_next(input logic q, input logic set, input logic clr);
		if (set && !clr) begin
			return 1'b1;
		end else if (clr && !set) begin
			return 1'b0;
		end
		return q;
	endfunction

	// Blanking next state, shared with the combined blank
	assign hblank_nxt = sr_next(hblank, h_pos == hbb, h_pos == hbe);
	assign vblank_nxt = sr_next(vblank, v_pos == vbb, v_pos == vbe);

	always_ff @(posedge sys_clk) begin
		if (!resetl || !viden) begin
			hblank <= 1'b0;
			vblank <= 1'b0;
			blank <= 1'b0;
			hsync <= 1'b0;
			vsync <= 1'b0;
			v_win <= 1'b0;
			vactive <= 1'b0;
			vint <= 1'b0;
		end else begin
			// Pulse only on the qualifying strobe, low again on the next cycle
			vint <= pix_en && (v_pos == vi) && (h_pos == hde);
			if (pix_en) begin
				hblank <= hblank_nxt;
				vblank <= vblank_nxt;
				blank <= hblank_nxt | vblank_nxt;
				// Syncs end on their own counter wrap
				hsync <= sr_next(hsync, h_pos == hs, h_wrap);
				vsync <= sr_next(vsync, v_pos == vs, v_wrap);
				// Lines that carry display
				v_win <= sr_next(v_win, v_pos == vdb, v_pos == vde);
				// Display span within a displayed line
				vactive <= sr_next(vactive, (h_pos == hdb) && v_win, h_pos == hde);
			end
		end
	end

	// At most one interrupt pulse per strobe, h position always moves between strobes
	a_vint_single: assert property (@(posedge sys_clk) disable iff (!resetl)
		vint |=> !vint)
		else $error("vint high on two consecutive cycles");

endmodule

// File: logic/vid_counter.sv
/* Position counter that advances on en and wraps to 0 after reaching period
   If period is lowered below count, count runs on to the width limit before it wraps */
`timescale 1ns/1ps

module vid_counter #(
	parameter int cnt_w = vid_pkg::HPOS_W
) (
	input  logic             sys_clk,
	input  logic             resetl,
	input  logic             clear,
	input  logic             en,
	input  logic [cnt_w-1:0] period,
	output logic [cnt_w-1:0] count,
	output logic             toggle,
	output logic             wrap
);

	logic at_end;

	// Last position of the period
	assign at_end = (count == period);

	// Same-cycle strobe, chains into the next counter's enable
	assign wrap = en & at_end;

	always_ff @(posedge sys_clk) begin
		if (!resetl || clear) begin
			count <= '0;
			toggle <= 1'b0;
		end else if (en) begin
			if (at_end) begin
				count <= '0;
				// Half or field flips on every wrap
				toggle <= ~toggle;
			end else begin
				count <= count + 1'b1;
			end
		end
	end

	// Once inside the period, count stays there while period is unchanged
	a_count_in_range: assert property (@(posedge sys_clk) disable iff (!resetl || clear)
		($stable(period) && $past(count <= period)) |-> (count <= period))
		else $error("count %0d above period %0d", count, period);

endmodule

// File: logic/vid_regs.sv
/* Write-only register file, a write lands on the cycle after the wr strobe
   Only the mode register resets, timing registers hold garbage until programmed */
`timescale 1ns/1ps

module vid_regs #(
	parameter int hpos_w = vid_pkg::HPOS_W,
	parameter int vpos_w = vid_pkg::VPOS_W
) (
	input  logic                      sys_clk,
	input  logic                      resetl,
	input  logic                      wr,
	input  logic [vid_pkg::ADDR_W-1:0] addr,
	input  logic [vid_pkg::DATA_W-1:0] data,
	output logic                      viden,
	output logic [hpos_w-1:0]         h_period,
	output logic [hpos_w:0]           hbb,
	output logic [hpos_w:0]           hbe,
	output logic [hpos_w:0]           hdb,
	output logic [hpos_w:0]           hde,
	output logic [hpos_w:0]           hs,
	output logic [vpos_w-1:0]         v_period,
	output logic [vpos_w:0]           vbb,
	output logic [vpos_w:0]           vbe,
	output logic [vpos_w:0]           vdb,
	output logic [vpos_w:0]           vde,
	output logic [vpos_w:0]           vs,
	output logic [vpos_w:0]           vi
);

	// Mode register, video starts disabled
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			viden <= 1'b0;
		end else if (wr && addr == vid_pkg::REG_MODE) begin
			viden <= data[vid_pkg::MODE_VIDEN];
		end
	end

	// Timing compare registers
	always_ff @(posedge sys_clk) begin
		if (wr) begin
			case (addr)
				// Periods have no half or field bit
				vid_pkg::REG_HP: h_period <= data[hpos_w-1:0];
				vid_pkg::REG_HBB: hbb <= data[hpos_w:0];
				vid_pkg::REG_HBE: hbe <= data[hpos_w:0];
				vid_pkg::REG_HDB: hdb <= data[hpos_w:0];
				vid_pkg::REG_HDE: hde <= data[hpos_w:0];
				vid_pkg::REG_HS: hs <= data[hpos_w:0];
				vid_pkg::REG_VP: v_period <= data[vpos_w-1:0];
				vid_pkg::REG_VBB: vbb <= data[vpos_w:0];
				vid_pkg::REG_VBE: vbe <= data[vpos_w:0];
				vid_pkg::REG_VDB: vdb <= data[vpos_w:0];
				vid_pkg::REG_VDE: vde <= data[vpos_w:0];
				vid_pkg::REG_VS: vs <= data[vpos_w:0];
				vid_pkg::REG_VI: vi <= data[vpos_w:0];
				// Mode handled above, unused addresses ignored
				default: ;
			endcase
		end
	end

	// Host must present a valid address with every write strobe
	a_addr_known: assert property (@(posedge sys_clk) disable iff (!resetl)
		wr |-> !$isunknown(addr))
		else $error("write strobe with unknown address");

endmodule

// File: logic/vid_pkg.sv
/* Widths, register map and mode bits shared by the video timing blocks
   Compare registers hold the count plus its half or field bit, so DATA_W must cover VPOS_W+1 */

package vid_pkg;

	// Horizontal count, half bit excluded
	parameter int HPOS_W = 10;
	// Vertical half-line count, field bit excluded
	parameter int VPOS_W = 11;

	// Register write port
	parameter int DATA_W = 12;
	parameter int ADDR_W = 4;

	// Mode register
	parameter logic [ADDR_W-1:0] REG_MODE = 4'h0;

	// Horizontal timing, in pixels with the half bit on top
	parameter logic [ADDR_W-1:0] REG_HP  = 4'h1;
	parameter logic [ADDR_W-1:0] REG_HBB = 4'h2;
	parameter logic [ADDR_W-1:0] REG_HBE = 4'h3;
	parameter logic [ADDR_W-1:0] REG_HDB = 4'h4;
	parameter logic [ADDR_W-1:0] REG_HDE = 4'h5;
	parameter logic [ADDR_W-1:0] REG_HS  = 4'h6;

	// Vertical timing, in half-lines with the field bit on top
	parameter logic [ADDR_W-1:0] REG_VP  = 4'h7;
	parameter logic [ADDR_W-1:0] REG_VBB = 4'h8;
	parameter logic [ADDR_W-1:0] REG_VBE = 4'h9;
	parameter logic [ADDR_W-1:0] REG_VDB = 4'ha;
	parameter logic [ADDR_W-1:0] REG_VDE = 4'hb;
	parameter logic [ADDR_W-1:0] REG_VS  = 4'hc;
	// Line that raises the vertical interrupt
	parameter logic [ADDR_W-1:0] REG_VI  = 4'hd;

	// Mode bits
	// Video enable, counters and flags held clear while low
	parameter int MODE_VIDEN = 0;

endpackage
